// File: samplerz.f
design/samplerz_pkg.sv
design/base_sampler.sv
design/ber_exp.sv
design/sampling_lane.sv
design/lane_select.sv
design/samplerz_ctrl.sv
design/samplerz_top.sv
sim/samplerz_properties.sv
sim/samplerz_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the samplerz testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module samplerz_tb \
  -f samplerz.f -o samplerz_sim
./obj_dir/samplerz_sim 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi

// File: sim/samplerz_tb.sv
/*
 * samplerz testbench
 *   xorshift stimulus, lane reference model, output and request checks
 */
`timescale 1ns/1ns

module samplerz_tb;

  localparam int NUM_LANES   = 2;
  localparam int NUM_SAMPLES = 200;
  localparam int TIMEOUT     = NUM_SAMPLES * 64 * 16;  // 64 attempts of 16 cycles
  localparam logic [31:0] SEED = 32'h5b40;

  logic                     clk = 1'b0;
  logic                     rst_i;
  logic                     din_val_i;
  samplerz_pkg::mu_t        mu_i;
  samplerz_pkg::scale_t     inv_sigma_sqr_div_2_i;
  logic                     rand_val_i;
  samplerz_pkg::lane_rand_t rand_i [NUM_LANES];
  logic                     ready_o;
  logic                     request_rand_o;
  logic                     dout_val_o;
  samplerz_pkg::z_t         w_o;

  logic [31:0]          din_rng  = SEED;
  logic [31:0]          lane_rng = SEED ^ 32'h0000_a5a5;  // separate stream for random sets
  samplerz_pkg::mu_t    cur_mu;        // sample in flight
  samplerz_pkg::scale_t cur_inv_s;
  samplerz_pkg::z_t     exp_w [$];     // model results in input order
  int                   attempts = 0;  // model attempts for the current sample
  int                   rejects = 0;   // model attempts where every lane rejected
  int                   requests = 0;  // request pulses seen for the current sample
  logic                 model_accepted = 1'b0;
  int                   in_cnt = 0;
  int                   out_cnt = 0;
  int                   cycle_cnt = 0;
  int                   val_errs = 0;
  int                   proto_errs = 0;

  samplerz_top #(
    .NUM_LANES (NUM_LANES)
  ) i_samplerz_top (
    .clk                   (clk),
    .rst_i                 (rst_i),
    .din_val_i             (din_val_i),
    .mu_i                  (mu_i),
    .inv_sigma_sqr_div_2_i (inv_sigma_sqr_div_2_i),
    .rand_val_i            (rand_val_i),
    .rand_i                (rand_i),
    .ready_o               (ready_o),
    .request_rand_o        (request_rand_o),
    .dout_val_o            (dout_val_o),
    .w_o                   (w_o)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT) begin
      $display("timeout after %0d cycles with %0d samples out", cycle_cnt, out_cnt);
      $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
      $display("TB FAILED");
      $finish;
    end
  end

  // ========================================
  // random numbers and reference model
  // ========================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic draw_lane_rand(output samplerz_pkg::lane_rand_t lr);
    logic [31:0] a;
    logic [31:0] b;
    lane_rng = xorshift32(lane_rng);
    a = lane_rng;
    lane_rng = xorshift32(lane_rng);
    b = lane_rng;
    lane_rng = xorshift32(lane_rng);
    lr.rand72 = {a[7:0], b, lane_rng};
    lr.rand8  = a[15:8];
    lr.b      = a[16];  // sign bit
  endtask

  // z0 counts the reverse CDT entries above the random word
  function automatic int cdt_count(input samplerz_pkg::rand72_t v);
    int n;
    n = 0;
    for (int i = 0; i < samplerz_pkg::CDT_LEN; i++) begin
      if (samplerz_pkg::CDT_TABLE[i] > v) begin
        n++;
      end
    end
    return n;
  endfunction

  // one lane in wide integers with Q16.16 values
  task automatic model_lane(input samplerz_pkg::lane_rand_t lr, input samplerz_pkg::mu_t mu,
                            input samplerz_pkg::scale_t inv_s, output logic acc, output int z);
    int         z0;
    longint     d;
    longint     d_sqr;
    longint     x;
    logic [3:0] k;
    z0    = cdt_count(lr.rand72);
    z     = lr.b ? z0 + 1 : -z0;
    d     = longint'(z) * 65536 - longint'(mu[15:0]);  // z - r
    d_sqr = (d * d) >>> 16;
    x     = ((d_sqr * longint'(inv_s)) >>> 16)
          - longint'(z0 * z0) * longint'(samplerz_pkg::INV_SIGMA_MAX_SQR_DIV_2);
    if (x < 0) begin
      x = 0;
    end
    k   = ((x >>> 14) > 15) ? 4'd15 : 4'(x >>> 14);  // saturated quarter steps
    acc = lr.rand8 < samplerz_pkg::EXP_TABLE[k];
  endtask

  // ========================================
  // random set replies
  // ========================================
  initial begin : rand_responder
    samplerz_pkg::lane_rand_t set [NUM_LANES];
    logic                     acc;
    int                       z;
    int                       delay;
    forever begin
      @(posedge clk);
      #1;
      if (request_rand_o) begin
        assert (!model_accepted) else begin
          $display("request_rand_o after the model accepted attempt %0d", attempts);
          proto_errs++;
        end
        lane_rng = xorshift32(lane_rng);
        delay = 1 + int'(lane_rng % 32'd3);  // 1..3 cycles
        repeat (delay) @(posedge clk);
        #1;
        for (int l = 0; l < NUM_LANES; l++) begin
          draw_lane_rand(set[l]);
        end
        rand_i     = set;
        rand_val_i = 1'b1;
        attempts++;
        for (int l = 0; l < NUM_LANES; l++) begin
          model_lane(set[l], cur_mu, cur_inv_s, acc, z);
          if (acc && !model_accepted) begin  // lowest lane wins
            model_accepted = 1'b1;
            exp_w.push_back(samplerz_pkg::z_t'(z + int'(cur_mu >>> 16)));
          end
        end
        if (!model_accepted) begin
          rejects++;
        end
        @(posedge clk);
        #1;
        // stray strobe with other data while the lanes run
        for (int l = 0; l < NUM_LANES; l++) begin
          draw_lane_rand(rand_i[l]);
        end
        @(posedge clk);
        #1;
        rand_val_i = 1'b0;
      end
    end
  end

  // ========================================
  // output monitor
  // ========================================
  initial begin : output_monitor
    samplerz_pkg::z_t exp_val;
    forever begin
      @(posedge clk);
      #1;
      if (request_rand_o) begin
        requests++;
      end
      if (dout_val_o) begin
        out_cnt++;
        assert (out_cnt == in_cnt) else begin
          $display("dout_val_o pulse %0d with %0d samples accepted", out_cnt, in_cnt);
          proto_errs++;
        end
        assert (exp_w.size() > 0) else begin
          $display("dout_val_o while every model lane rejected");
          proto_errs++;
        end
        if (exp_w.size() > 0) begin
          exp_val = exp_w.pop_front();
          assert (w_o == exp_val) else begin
            $display("FAILED w_o: exp %h got %h (mu %h)", exp_val, w_o, cur_mu);
            val_errs++;
          end
        end
        assert (requests == rejects + 1) else begin
          $display("FAILED request_rand_o count: exp %h got %h", rejects + 1, requests);
          val_errs++;
        end
      end
    end
  end

  // ========================================
  // stimulus
  // ========================================
  initial begin : stimulus
    logic [31:0] v;
    rst_i                 = 1'b1;
    din_val_i             = 1'b0;
    mu_i                  = '0;
    inv_sigma_sqr_div_2_i = '0;
    rand_val_i            = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      rand_i[l] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_i = 1'b0;
    // idle after reset with one stray random strobe
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      assert (ready_o && !request_rand_o && !dout_val_o) else begin
        $display("outputs not idle after reset: ready %b request %b dout %b",
                 ready_o, request_rand_o, dout_val_o);
        proto_errs++;
      end
      rand_val_i = (i == 1);
    end
    for (int s = 0; s < NUM_SAMPLES; s++) begin
      while (!ready_o) begin
        @(posedge clk);
        #1;
      end
      din_rng = xorshift32(din_rng);
      v = din_rng;
      cur_mu = samplerz_pkg::mu_t'({{9{v[22]}}, v[22:0]});  // within +-64
      din_rng = xorshift32(din_rng);
      cur_inv_s = din_rng[15:0];
      attempts = 0;
      rejects = 0;
      requests = 0;
      model_accepted = 1'b0;
      din_val_i = 1'b1;
      mu_i = cur_mu;
      inv_sigma_sqr_div_2_i = cur_inv_s;
      in_cnt++;
      @(posedge clk);
      #1;
      repeat (2) begin  // junk sample while busy
        assert (!ready_o) else begin
          $display("ready_o high right after a sample was taken");
          proto_errs++;
        end
        mu_i = ~cur_mu;
        inv_sigma_sqr_div_2_i = ~cur_inv_s;
        @(posedge clk);
        #1;
      end
      din_val_i = 1'b0;
      wait (out_cnt == in_cnt);
    end
    repeat (20) @(posedge clk);  // room for stray pulses
    #1;
    assert (out_cnt == NUM_SAMPLES && exp_w.size() == 0) else begin
      $display("%0d of %0d samples out, %0d model results left",
               out_cnt, NUM_SAMPLES, exp_w.size());
      proto_errs++;
    end
    $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: sim/samplerz_properties.sv
/*
 * concurrent checks on the attempt control
 *   request/start ordering, ready level, no request before the first sample
 */
`timescale 1ns/1ns

module samplerz_properties (
  input logic clk,
  input logic rst_i,
  input logic din_val_i,
  input logic dout_val_i,
  input logic ready_i,
  input logic request_rand_i,
  input logic start_i
);

  logic din_seen;  // a sample was taken since reset
  logic busy;      // sample taken and its result not out yet
  logic req_open;  // request out and no start yet

  always_ff @(posedge clk) begin
    if (rst_i) begin
      din_seen <= 1'b0;
      busy     <= 1'b0;
    end else begin
      if (din_val_i && ready_i) begin
        din_seen <= 1'b1;
        busy     <= 1'b1;
      end else if (dout_val_i) begin
        busy <= 1'b0;
      end
    end
  end

  // each start answers exactly one request
  always_ff @(posedge clk) begin
    if (rst_i) begin
      req_open <= 1'b0;
    end else if (start_i) begin
      req_open <= 1'b0;
    end else if (request_rand_i) begin
      req_open <= 1'b1;
    end
  end

  // ========================================
  // properties
  // ========================================
  req_start_excl: assert property (@(posedge clk) disable iff (rst_i)
    request_rand_i |-> (!start_i && !req_open))
    else $error("request_rand with start or with an earlier request still open");

  start_after_req: assert property (@(posedge clk) disable iff (rst_i)
    start_i |-> req_open)
    else $error("start without a preceding request_rand");

  ready_low_busy: assert property (@(posedge clk) disable iff (rst_i)
    ready_i == !busy)
    else $error("ready does not follow the sample in flight");

  no_early_req: assert property (@(posedge clk) disable iff (rst_i)
    !din_seen |-> !request_rand_i)
    else $error("request_rand before any sample was taken");

endmodule

bind samplerz_ctrl samplerz_properties i_samplerz_properties (
  .clk            (clk),
  .rst_i          (rst_i),
  .din_val_i      (din_val_i),
  .dout_val_i     (dout_val_i),
  .ready_i        (ready_o),
  .request_rand_i (request_rand_o),
  .start_i        (start_o)
);

// File: design/samplerz_top.sv
/*
 * discrete gaussian sampler, top level
 *   ctrl, NUM_LANES sampling lanes (1..6), lane select
 */
`timescale 1ns/1ns

module samplerz_top #(
  parameter int NUM_LANES = 2
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     din_val_i,
  input  samplerz_pkg::mu_t        mu_i,
  input  samplerz_pkg::scale_t     inv_sigma_sqr_div_2_i,
  input  logic                     rand_val_i,
  input  samplerz_pkg::lane_rand_t rand_i [NUM_LANES],
  output logic                     ready_o,
  output logic                     request_rand_o,
  output logic                     dout_val_o,
  output samplerz_pkg::z_t         w_o
);

  logic                       start;
  samplerz_pkg::lane_rand_t   lane_rand [NUM_LANES];
  samplerz_pkg::frac_t        r;
  samplerz_pkg::scale_t       inv_s;
  samplerz_pkg::z_t           floor_mu;
  logic [NUM_LANES-1:0]       res_val;
  samplerz_pkg::lane_result_t res [NUM_LANES];
  logic                       all_reject;

  samplerz_ctrl #(
    .NUM_LANES (NUM_LANES)
  ) i_samplerz_ctrl (
    .clk                   (clk),
    .rst_i                 (rst_i),
    .din_val_i             (din_val_i),
    .mu_i                  (mu_i),
    .inv_sigma_sqr_div_2_i (inv_sigma_sqr_div_2_i),
    .rand_val_i            (rand_val_i),
    .rand_i                (rand_i),
    .all_reject_i          (all_reject),
    .dout_val_i            (dout_val_o),
    .ready_o               (ready_o),
    .request_rand_o        (request_rand_o),
    .start_o               (start),
    .lane_rand_o           (lane_rand),
    .r_o                   (r),
    .inv_s_o               (inv_s),
    .floor_mu_o            (floor_mu)
  );

  // lanes share start, r and inv_s, each gets its own random set
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    sampling_lane i_sampling_lane (
      .clk         (clk),
      .rst_i       (rst_i),
      .start_i     (start),
      .lane_rand_i (lane_rand[g]),
      .r_i         (r),
      .inv_s_i     (inv_s),
      .res_val_o   (res_val[g]),
      .res_o       (res[g])
    );
  end

  lane_select #(
    .NUM_LANES (NUM_LANES)
  ) i_lane_select (
    .clk          (clk),
    .rst_i        (rst_i),
    .res_val_i    (res_val),
    .res_i        (res),
    .floor_mu_i   (floor_mu),
    .dout_val_o   (dout_val_o),
    .w_o          (w_o),
    .all_reject_o (all_reject)
  );

endmodule

// File: design/samplerz_ctrl.sv
/*
 * attempt control
 *   IDLE / WAIT_RAND / RUN state machine, request_rand pulse
 *   input latches, mu split into floor and fraction, random set register
 */
`timescale 1ns/1ns

module samplerz_ctrl #(
  parameter int NUM_LANES = 2
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     din_val_i,
  input  samplerz_pkg::mu_t        mu_i,
  input  samplerz_pkg::scale_t     inv_sigma_sqr_div_2_i,
  input  logic                     rand_val_i,
  input  samplerz_pkg::lane_rand_t rand_i [NUM_LANES],
  input  logic                     all_reject_i,
  input  logic                     dout_val_i,
  output logic                     ready_o,
  output logic                     request_rand_o,
  output logic                     start_o,
  output samplerz_pkg::lane_rand_t lane_rand_o [NUM_LANES],
  output samplerz_pkg::frac_t      r_o,
  output samplerz_pkg::scale_t     inv_s_o,
  output samplerz_pkg::z_t         floor_mu_o
);

  samplerz_pkg::ctrl_state_t state_q;
  samplerz_pkg::mu_t         mu_q;
  logic                      din_acc;   // new sample taken
  logic                      rand_acc;  // random set taken

  assign ready_o  = (state_q == samplerz_pkg::IDLE);
  assign din_acc  = din_val_i & ready_o;
  assign rand_acc = rand_val_i & (state_q == samplerz_pkg::WAIT_RAND);

  // ========================================
  // state machine
  // ========================================
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q        <= samplerz_pkg::IDLE;
      request_rand_o <= 1'b0;
      start_o        <= 1'b0;
    end else begin
      request_rand_o <= 1'b0;  // both are single cycle pulses
      start_o        <= 1'b0;
      case (state_q)
        samplerz_pkg::IDLE: begin
          if (din_acc) begin
            state_q        <= samplerz_pkg::WAIT_RAND;
            request_rand_o <= 1'b1;
          end
        end
        samplerz_pkg::WAIT_RAND: begin
          if (rand_acc) begin
            state_q <= samplerz_pkg::RUN;
            start_o <= 1'b1;  // set is in lane_rand_o this same cycle
          end
        end
        samplerz_pkg::RUN: begin
          if (dout_val_i) begin
            state_q <= samplerz_pkg::IDLE;
          end else if (all_reject_i) begin
            state_q        <= samplerz_pkg::WAIT_RAND;  // fresh randomness
            request_rand_o <= 1'b1;
          end
        end
        default: state_q <= samplerz_pkg::IDLE;
      endcase
    end
  end

  // ========================================
  // input latches
  // ========================================
  always_ff @(posedge clk) begin
    if (din_acc) begin
      mu_q    <= mu_i;
      inv_s_o <= inv_sigma_sqr_div_2_i;
    end
  end

  // one set per attempt, stable until the next WAIT_RAND
  always_ff @(posedge clk) begin
    if (rand_acc) begin
      lane_rand_o <= rand_i;
    end
  end

  // two's complement split gives floor for negative mu too,
  // e.g. -1.25 -> floor -2, r 0.75
  assign floor_mu_o = mu_q[31:16];
  assign r_o        = mu_q[15:0];

endmodule

// File: design/lane_select.sv
/*
 * lane result selection
 *   lowest accepting lane wins, output offset by floor(mu)
 *   all-reject pulse when no lane accepts
 */
`timescale 1ns/1ns

module lane_select #(
  parameter int NUM_LANES = 2
) (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic [NUM_LANES-1:0]       res_val_i,
  input  samplerz_pkg::lane_result_t res_i [NUM_LANES],
  input  samplerz_pkg::z_t           floor_mu_i,
  output logic                       dout_val_o,
  output samplerz_pkg::z_t           w_o,
  output logic                       all_reject_o
);

  logic             any_val;  // lanes run in lockstep
  logic             hit;      // some lane accepted
  samplerz_pkg::z_t win_z;

  assign any_val = |res_val_i;

  // walk down so the lowest index is the last to write
  always_comb begin
    hit   = 1'b0;
    win_z = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (res_val_i[i] && res_i[i].accept) begin
        hit   = 1'b1;
        win_z = res_i[i].z;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      dout_val_o   <= 1'b0;
      all_reject_o <= 1'b0;
    end else begin
      dout_val_o   <= any_val & hit;
      all_reject_o <= any_val & ~hit;  // retry request to ctrl
    end
  end

  always_ff @(posedge clk) begin
    if (any_val && hit) begin
      w_o <= win_z + floor_mu_i;
    end
  end

endmodule

// File: design/sampling_lane.sv
/*
 * one sampling lane
 *   base sampler, sign combine, rejection exponent, bernoulli trial
 *   result valid 7 cycles after start
 */
`timescale 1ns/1ns

module sampling_lane (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       start_i,
  input  samplerz_pkg::lane_rand_t   lane_rand_i,  // held by ctrl for the attempt
  input  samplerz_pkg::frac_t        r_i,
  input  samplerz_pkg::scale_t       inv_s_i,
  output logic                       res_val_o,
  output samplerz_pkg::lane_result_t res_o
);

  logic [7:1]               vld_sr;        // stage valids
  samplerz_pkg::z_t         z0_q;          // stage 1
  samplerz_pkg::z_t         z_sr [2:7];    // z from stage 2 to the output
  samplerz_pkg::fix_t       z0_sqr_q;      // stage 2, integer
  samplerz_pkg::fix_t       z0_sqr_d3;
  samplerz_pkg::fix_t       z0_sqr_d4;
  samplerz_pkg::fix_t       d_q;           // stage 3, z - r
  samplerz_pkg::fix_t       d_sqr_q;       // stage 4
  logic signed [63:0]       d_sqr_full;
  logic        [63:0]       part1_full;
  samplerz_pkg::fix_t       part1_q;       // stage 5, d^2 * inv_s
  samplerz_pkg::fix_t       part2_q;       // stage 5, z0^2 * inv_sigma_max
  samplerz_pkg::fix_t       x_q;           // stage 6
  logic                     accept;        // stage 7

  // valid shift register, the only reset state in the lane
  always_ff @(posedge clk) begin
    if (rst_i) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[6:1], start_i};
    end
  end

  // ========================================
  // stage 1: z0 from the CDT
  // ========================================
  base_sampler i_base_sampler (
    .clk      (clk),
    .rand72_i (lane_rand_i.rand72),
    .z0_o     (z0_q)
  );

  // ========================================
  // stages 2..6: arithmetic
  // ========================================
  assign d_sqr_full = 64'(d_q) * 64'(d_q);           // Q32.32
  assign part1_full = 64'(d_sqr_q) * 64'(inv_s_i);   // Q16.32, both >= 0

  always_ff @(posedge clk) begin
    // b = 1 -> 1 + z0, b = 0 -> -z0
    z_sr[2]   <= lane_rand_i.b ? z0_q + 16'sd1 : -z0_q;
    z0_sqr_q  <= samplerz_pkg::fix_t'(z0_q) * samplerz_pkg::fix_t'(z0_q);

    d_q       <= samplerz_pkg::fix_t'({z_sr[2], 16'h0000})
               - samplerz_pkg::fix_t'({16'h0000, r_i});  // z - r in Q16.16
    z0_sqr_d3 <= z0_sqr_q;

    d_sqr_q   <= d_sqr_full[47:16];   // back to Q16.16, |d| < 20 so no overflow
    z0_sqr_d4 <= z0_sqr_d3;

    part1_q   <= part1_full[47:16];
    part2_q   <= z0_sqr_d4 *
                 samplerz_pkg::fix_t'({16'h0000, samplerz_pkg::INV_SIGMA_MAX_SQR_DIV_2});

    // rounding can push x slightly below zero
    x_q       <= (part1_q < part2_q) ? '0 : part1_q - part2_q;
  end

  // z rides along with the arithmetic
  always_ff @(posedge clk) begin
    for (int k = 3; k <= 7; k++) begin
      z_sr[k] <= z_sr[k-1];
    end
  end

  // ========================================
  // stage 7: bernoulli trial
  // ========================================
  ber_exp i_ber_exp (
    .clk      (clk),
    .x_i      (x_q),
    .rand8_i  (lane_rand_i.rand8),
    .accept_o (accept)
  );

  assign res_val_o  = vld_sr[7];
  assign res_o      = '{accept: accept, z: z_sr[7]};

endmodule

// File: design/ber_exp.sv
/*
 * bernoulli trial with probability exp(-x)
 *   quarter step index, saturating lookup, compare against 8 random bits
 */
`timescale 1ns/1ns

module ber_exp (
  input  logic                 clk,
  input  samplerz_pkg::fix_t   x_i,      // Q16.16, >= 0 from the lane
  input  samplerz_pkg::rand8_t rand8_i,
  output logic                 accept_o
);

  samplerz_pkg::fix_t x_steps;  // x in units of 0.25
  logic [3:0]         k;        // table index

  assign x_steps = x_i >>> samplerz_pkg::EXP_INDEX_SHIFT;

  always_comb begin
    if (x_steps < 0) begin
      k = 4'd0;                 // negative x treated as zero
    end else if (x_steps > 15) begin
      k = 4'd15;                // tail saturates at exp(-3.75)
    end else begin
      k = x_steps[3:0];
    end
  end

  // accept with probability EXP_TABLE[k]/256
  always_ff @(posedge clk) begin
    accept_o <= (rand8_i < samplerz_pkg::EXP_TABLE[k]);
  end

endmodule

// File: design/base_sampler.sv
/*
 * base sampler
 *   z0 from the reverse CDT, one register stage
 */
`timescale 1ns/1ns

module base_sampler (
  input  logic                  clk,
  input  samplerz_pkg::rand72_t rand72_i,
  output samplerz_pkg::z_t      z0_o
);

  samplerz_pkg::z_t cnt;  // entries above the random word

  // constant-time count over the full table
  always_comb begin
    cnt = '0;
    for (int i = 0; i < samplerz_pkg::CDT_LEN; i++) begin
      if (rand72_i < samplerz_pkg::CDT_TABLE[i]) begin
        cnt = cnt + 16'sd1;
      end
    end
  end

  // comparator tree is the long path here, register right after
  always_ff @(posedge clk) begin
    z0_o <= cnt;  // 0..18
  end

endmodule

// File: design/samplerz_pkg.sv
/*
 * shared definitions of the discrete gaussian sampler
 *   fixed point widths, lane structs, control FSM states
 *   reverse CDT, exp(-x) probability table, sigma_max scale
 */
package samplerz_pkg;

  // ========================================
  // widths with a meaning
  // ========================================
  typedef logic signed [31:0] mu_t;     // centre, signed Q16.16
  typedef logic        [15:0] scale_t;  // 1/(2 sigma^2), unsigned Q0.16
  typedef logic        [15:0] frac_t;   // fractional part of mu, Q0.16
  typedef logic signed [15:0] z_t;      // integer sample
  typedef logic signed [31:0] fix_t;    // Q16.16 intermediate (d, x, parts of x)
  typedef logic        [71:0] rand72_t; // base sampler random word
  typedef logic        [7:0]  rand8_t;  // bernoulli random word

  // one lane's share of a random set
  typedef struct packed {
    rand72_t rand72;
    rand8_t  rand8;
    logic    b;       // sign bit
  } lane_rand_t;

  typedef struct packed {
    logic accept;
    z_t   z;          // z before the floor(mu) offset
  } lane_result_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_RAND,        // request out, waiting for a random set
    RUN               // lanes busy
  } ctrl_state_t;

  // ========================================
  // tables and constants
  // ========================================
  localparam int CDT_LEN = 18;
  localparam int EXP_LEN = 16;

  // reverse cumulative table, z0 = number of entries above the random word
  localparam rand72_t CDT_TABLE [CDT_LEN] = '{
    72'd3024686241123004913666,
    72'd1564742784480091954050,
    72'd636254429462080897535,
    72'd199560484645026482916,
    72'd47667343854657281903,
    72'd8595902006365044063,
    72'd1163297957344668388,
    72'd117656387352093658,
    72'd8867391802663976,
    72'd496969357462633,
    72'd20680885154299,
    72'd638331848991,
    72'd14602316184,
    72'd247426747,
    72'd3104126,
    72'd28824,
    72'd198,
    72'd1
  };

  // 256*exp(-k/4), rounded, first entry saturated
  localparam rand8_t EXP_TABLE [EXP_LEN] = '{
    8'd255, 8'd199, 8'd155, 8'd121,
    8'd94,  8'd73,  8'd57,  8'd44,
    8'd35,  8'd27,  8'd21,  8'd16,
    8'd13,  8'd10,  8'd8,   8'd6
  };

  // 1/(2 sigma_max^2) with sigma_max = 1.8205, i.e. 0.15087 in Q0.16
  localparam scale_t INV_SIGMA_MAX_SQR_DIV_2 = 16'd9887;

  // Q16.16 >> 14 gives x in steps of 0.25
  localparam int EXP_INDEX_SHIFT = 14;

endpackage
